//--- vlog.f
rtl/uart_pkg.sv
rtl/core_pkg.sv
rtl/baud_rate_gen.sv
rtl/uart_receiver.sv
rtl/uart_transmitter.sv
rtl/fifo_transmitter.sv
rtl/debug_unit.sv
rtl/pipeline.sv
rtl/top_pipeline.sv
tests/tb_top_pipeline.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_top_pipeline
RTL_TOP   ?= top_pipeline
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "=== PASS ===" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/tb_top_pipeline.sv
`timescale 1ns/1ps

module tb_top_pipeline;
    import uart_pkg::*;
    import core_pkg::*;

    localparam int BIT_CLKS       = TICKS_PER_BIT * CLKS_PER_TICK;   // 64 cycles per bit
    localparam int FRAME_CLKS     = (DATA_BITS + 2) * BIT_CLKS;      // 2176 cycles per word
    localparam int WORDS_SENT     = 35;
    localparam int WORDS_EXPECTED = 77;                              // Seven dumps of 11
    localparam int QUIET_CLKS     = 3000;                            // Line watch after bad code
    localparam int WATCHDOG_CLKS  = (WORDS_SENT + WORDS_EXPECTED) * FRAME_CLKS * 2 + QUIET_CLKS;

    logic i_clk;
    logic i_reset;
    logic i_rx;
    logic o_tx;

    int seed         = 2864;
    int value_errors = 0;
    int other_errors = 0;

    logic [31:0] prog [$];                                  // Program for the next load
    logic [31:0] tb_imem [IMEM_DEPTH];                      // Host copy of instruction memory
    logic [31:0] dump_got [DUMP_WORDS];
    logic [31:0] dump_exp [DUMP_WORDS];
    logic [31:0] m_regs [REG_COUNT];                        // Reference model of the core
    logic [5:0]  m_pc;
    logic [31:0] m_retired;
    logic        m_s2_valid;
    logic [31:0] m_s2_instr;

    top_pipeline top_pipeline_i (.i_clk(i_clk), .i_reset(i_reset), .i_rx(i_rx), .o_tx(o_tx));

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;                         // 100 ns period
    end

    initial begin
        repeat (WATCHDOG_CLKS) @(posedge i_clk);
        $display("Watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CLKS);
        $display("=== FAIL ===");
        $finish;
    end

    function automatic logic [31:0] make_instr(input logic [3:0] op, input int rd,
                                               input int rs, input int rt,
                                               input logic [15:0] imm);
        return {op, 3'(rd), 3'(rs), 3'(rt), 3'b000, imm};
    endfunction

    function automatic logic [31:0] command(input logic [7:0] code, input int arg);
        return {code, 24'(arg)};                            // Code in the top byte
    endfunction

    function automatic logic model_halted();
        return m_s2_valid && (m_s2_instr[31:28] == 4'hF);   // HALT in stage 2 freezes core
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic model_reset();
        m_pc       = '0;
        m_retired  = '0;
        m_s2_valid = 1'b0;                                  // Bubble
        m_s2_instr = '0;
        for (int i = 0; i < REG_COUNT; i++)
            m_regs[i] = '0;
    endtask

    // Sequential ISA semantics; forwarding must make the core match this
    task automatic model_execute(input logic [31:0] ins);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        wr;
        a   = m_regs[ins[24:22]];
        b   = m_regs[ins[21:19]];
        wr  = 1'b1;
        res = '0;
        case (ins[31:28])
            4'd1:    res = a + {{16{ins[15]}}, ins[15:0]};  // ADDI
            4'd2:    res = a + b;
            4'd3:    res = a - b;
            4'd4:    res = a ^ b;
            default: wr = 1'b0;                             // NOP, HALT, unused codes
        endcase
        if (wr && ins[27:25] != 3'd0)
            m_regs[ins[27:25]] = res;                       // r0 stays zero
    endtask

    task automatic model_advance();
        if (!model_halted()) begin
            if (m_s2_valid) begin
                model_execute(m_s2_instr);                  // Retires as it leaves stage 2
                m_retired++;
            end
            m_s2_instr = tb_imem[m_pc];
            m_s2_valid = 1'b1;
            m_pc       = m_pc + 6'd1;
        end
    endtask

    task automatic model_run();
        for (int n = 0; n < 2 * IMEM_DEPTH && !model_halted(); n++)
            model_advance();
    endtask

    task automatic send_word(input logic [31:0] w);
        @(posedge i_clk);
        i_rx <= 1'b0;                                       // Start bit
        for (int i = 0; i < DATA_BITS; i++) begin
            repeat (BIT_CLKS) @(posedge i_clk);
            i_rx <= w[i];                                   // LSB first
        end
        repeat (BIT_CLKS) @(posedge i_clk);
        i_rx <= 1'b1;
        repeat (BIT_CLKS + 16) @(posedge i_clk);            // Stop bit and short idle gap
    endtask

    task automatic recv_word(output logic [31:0] w);
        w = '0;
        do @(negedge i_clk); while (o_tx !== 1'b0);         // Wait for start bit
        repeat (BIT_CLKS / 2) @(negedge i_clk);
        if (o_tx !== 1'b0) begin
            other_errors++;
            $display("Start bit on o_tx did not last to its middle");
        end
        for (int i = 0; i < DATA_BITS; i++) begin
            repeat (BIT_CLKS) @(negedge i_clk);
            w[i] = o_tx;                                    // Mid-bit sample
        end
        repeat (BIT_CLKS) @(negedge i_clk);
        if (o_tx !== 1'b1) begin
            other_errors++;
            $display("Stop bit missing on o_tx");
        end
    endtask

    task automatic load_program();
        send_word(command(CMD_LOAD, prog.size()));
        foreach (prog[i]) begin
            tb_imem[i] = prog[i];
            send_word(prog[i]);
        end
    endtask

    // Send a RUN or STEP and collect its dump while the command frame finishes
    task automatic run_command(input logic [31:0] cmd, input string tag);
        string name;
        fork
            send_word(cmd);
            for (int i = 0; i < DUMP_WORDS; i++)
                recv_word(dump_got[i]);
        join
        dump_exp[0] = {26'd0, m_pc};
        dump_exp[1] = m_s2_valid ? m_s2_instr : 32'd0;
        dump_exp[2] = m_retired;
        for (int i = 0; i < REG_COUNT; i++)
            dump_exp[3 + i] = m_regs[i];
        for (int i = 0; i < DUMP_WORDS; i++) begin
            case (i)
                0:       name = "pc";
                1:       name = "stage2_instr";
                2:       name = "retired";
                default: name = $sformatf("r%0d", i - 3);
            endcase
            check_value({tag, " ", name}, dump_got[i], dump_exp[i]);
        end
    endtask

    task automatic test_run_program();
        prog.delete();
        prog.push_back(make_instr(OP_ADDI, 1, 0, 0, 16'd5));
        prog.push_back(make_instr(OP_ADDI, 2, 0, 0, 16'hFFF9));    // -7
        prog.push_back(32'h0);                                      // NOP gap, no forwarding
        prog.push_back(make_instr(OP_ADD, 3, 1, 2, 16'd0));
        prog.push_back(make_instr(OP_HALT, 0, 0, 0, 16'd0));        // h = 4
        send_word(command(CMD_RESET, 0));
        load_program();
        model_reset();
        model_run();
        run_command(command(CMD_RUN, 0), "run");
        check_value("run pc rule", dump_got[0], 32'd5);
        check_value("run stage2_instr rule", dump_got[1], prog[4]);
        check_value("run retired rule", dump_got[2], 32'd4);
    endtask

    task automatic test_forwarding();
        int          prev_rd;
        int          rd;
        int          other;
        logic [3:0]  op;
        logic [15:0] imm;
        prog.delete();
        prev_rd = 0;
        for (int i = 0; i < 8; i++) begin
            rd    = 1 + (($random(seed) & 32'h7FFF_FFFF) % 7);
            other = $random(seed) & 7;
            imm   = 16'($random(seed));
            case (i % 4)
                0:       op = OP_ADDI;
                1:       op = OP_ADD;
                2:       op = OP_SUB;
                default: op = OP_XOR;
            endcase
            if (op == OP_SUB)
                prog.push_back(make_instr(op, rd, other, prev_rd, imm));  // Forward into rt
            else
                prog.push_back(make_instr(op, rd, prev_rd, other, imm));  // Forward into rs
            prev_rd = rd;
        end
        prog.push_back(make_instr(OP_HALT, 0, 0, 0, 16'd0));
        send_word(command(CMD_RESET, 0));
        load_program();
        model_reset();
        model_run();
        run_command(command(CMD_RUN, 0), "forward");
    endtask

    task automatic test_single_steps();
        send_word(command(CMD_RESET, 0));
        model_reset();
        for (int k = 1; k <= 3; k++) begin
            model_advance();
            run_command(command(CMD_STEP, 0), "step");
            check_value("step pc rule", dump_got[0], 32'(k));
            check_value("step stage2_instr rule", dump_got[1], tb_imem[k-1]);
            check_value("step retired rule", dump_got[2], 32'(k - 1));
        end
    endtask

    task automatic test_r0_writes();
        prog.delete();
        prog.push_back(make_instr(OP_ADDI, 0, 0, 0, 16'($random(seed))));
        prog.push_back(make_instr(OP_ADDI, 1, 0, 0, 16'h0123));
        prog.push_back(make_instr(OP_ADD, 0, 1, 1, 16'd0));
        prog.push_back(make_instr(OP_ADDI, 2, 0, 0, 16'd1));       // Must not see r0 write
        prog.push_back(make_instr(OP_HALT, 0, 0, 0, 16'd0));
        send_word(command(CMD_RESET, 0));
        load_program();
        model_reset();
        model_run();
        run_command(command(CMD_RUN, 0), "r0");
        check_value("r0 rule", dump_got[3], 32'd0);
    endtask

    task automatic test_core_reset();
        send_word(command(CMD_RESET, 0));                   // Core halted with live registers
        model_reset();
        model_advance();
        run_command(command(CMD_STEP, 0), "reset");
        check_value("reset pc rule", dump_got[0], 32'd1);
        check_value("reset retired rule", dump_got[2], 32'd0);
        check_value("reset stage2_instr rule", dump_got[1], tb_imem[0]);
        send_word(command(8'h7E, 0));                       // Unknown code
        for (int i = 0; i < QUIET_CLKS; i++) begin
            @(negedge i_clk);
            if (o_tx !== 1'b1) begin
                other_errors++;
                $display("Start bit appeared on o_tx after an unknown command");
                break;
            end
        end
    endtask

    initial begin
        i_reset = 1'b1;
        i_rx    = 1'b1;                                     // Serial idle level
        for (int i = 0; i < IMEM_DEPTH; i++)
            tb_imem[i] = '0;
        repeat (16) @(posedge i_clk);
        i_reset <= 1'b0;
        repeat (4) @(posedge i_clk);
        test_run_program();
        test_forwarding();
        test_single_steps();
        test_r0_writes();
        test_core_reset();
        $display("Tests done with %0d value errors and %0d other errors",
                 value_errors, other_errors);
        if (value_errors + other_errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- rtl/top_pipeline.sv
`timescale 1ns/1ps

module top_pipeline (
    input  logic i_clk,
    input  logic i_reset,
    input  logic i_rx,                                  // Serial line from the host
    output logic o_tx                                   // Serial line to the host
);
    import uart_pkg::*;
    import core_pkg::*;

    logic                 baud_tick;
    logic                 rx_done;
    logic [DATA_BITS-1:0] rx_data;
    logic                 fifo_wr;
    logic [DATA_BITS-1:0] fifo_wr_data;
    logic [DATA_BITS-1:0] fifo_head;
    logic                 fifo_empty;
    logic                 tx_done;
    logic                 advance;
    logic                 reset_from_debug;
    logic                 core_reset;
    logic                 imem_we;
    logic [PC_BITS-1:0]   imem_addr;
    logic [XLEN-1:0]      imem_data;
    logic [REG_BITS-1:0]  reg_addr;
    logic [XLEN-1:0]      reg_data;
    ex_latch_t            ex_latch;
    logic [PC_BITS-1:0]   pc;
    logic [XLEN-1:0]      retired;
    logic                 program_end;

    assign core_reset = i_reset | reset_from_debug;     // CMD_RESET reaches the core only

    baud_rate_gen u_baud_rate_gen (
        .i_clk(i_clk), .i_reset(i_reset), .o_baud_tick(baud_tick)
    );

    uart_receiver u_uart_receiver (
        .i_clk(i_clk), .i_reset(i_reset), .i_rx(i_rx), .i_bd_tick(baud_tick),
        .o_rx_done(rx_done), .o_data(rx_data)
    );

    fifo_transmitter u_fifo_transmitter (
        .i_clk(i_clk), .i_reset(i_reset), .i_wr(fifo_wr), .i_rd(tx_done),
        .i_wr_data(fifo_wr_data), .o_rd_data(fifo_head), .o_empty(fifo_empty),
        .o_full()                                       // 16 entries cover one dump
    );

    uart_transmitter u_uart_transmitter (
        .i_clk(i_clk), .i_reset(i_reset), .i_tx_start(~fifo_empty), .i_bd_tick(baud_tick),
        .i_data(fifo_head), .o_tx_done(tx_done), .o_tx(o_tx)
    );

    debug_unit u_debug_unit (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_data_ready(rx_done), .i_data(rx_data),
        .i_program_end(program_end), .i_ex_latch(ex_latch), .i_pc(pc),
        .i_retired(retired), .i_reg_data(reg_data),
        .o_advance(advance), .o_core_reset(reset_from_debug),
        .o_imem_we(imem_we), .o_imem_addr(imem_addr), .o_imem_data(imem_data),
        .o_reg_addr(reg_addr),
        .o_data_to_fifo(fifo_wr_data), .o_write_en_fifo(fifo_wr)
    );

    pipeline u_pipeline (
        .i_clk(i_clk), .i_reset(core_reset), .i_advance(advance),
        .i_imem_we(imem_we), .i_imem_addr(imem_addr), .i_imem_data(imem_data),
        .i_reg_addr(reg_addr), .o_reg_data(reg_data),
        .o_ex_latch(ex_latch), .o_pc(pc), .o_retired(retired),
        .o_program_end(program_end)
    );

endmodule

//--- rtl/pipeline.sv
`timescale 1ns/1ps

module pipeline (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  logic                          i_advance,     // One pipeline step per cycle high
    input  logic                          i_imem_we,
    input  logic [core_pkg::PC_BITS-1:0]  i_imem_addr,
    input  logic [core_pkg::XLEN-1:0]     i_imem_data,
    input  logic [core_pkg::REG_BITS-1:0] i_reg_addr,    // Debug read port
    output logic [core_pkg::XLEN-1:0]     o_reg_data,
    output core_pkg::ex_latch_t           o_ex_latch,    // Stage 2 contents
    output logic [core_pkg::PC_BITS-1:0]  o_pc,
    output logic [core_pkg::XLEN-1:0]     o_retired,
    output logic                          o_program_end
);
    import core_pkg::*;

    logic [XLEN-1:0] imem [IMEM_DEPTH];                 // Survives a core reset
    logic [XLEN-1:0] regs [REG_COUNT];
    instr_t          fetch;
    opcode_t         fetch_op;
    logic [XLEN-1:0] imm_ext;
    logic [XLEN-1:0] rs_val;
    logic [XLEN-1:0] rt_val;
    logic [XLEN-1:0] alu_result;
    logic            wb_en;
    logic            step;

    assign fetch         = imem[o_pc];
    assign imm_ext       = {{(XLEN - 16){fetch.imm[15]}}, fetch.imm};
    assign o_reg_data    = regs[i_reg_addr];
    assign o_program_end = o_ex_latch.valid && (o_ex_latch.op == OP_HALT);
    assign step          = i_advance && !o_program_end;  // Frozen on HALT

    // Stage 1 decode
    always_comb begin
        case (fetch.opcode)
            OP_ADDI, OP_ADD, OP_SUB, OP_XOR, OP_HALT: fetch_op = opcode_t'(fetch.opcode);
            default: fetch_op = OP_NOP;                 // Unused codes behave as NOP
        endcase
    end

    // Stage 2 ALU
    always_comb begin
        wb_en = o_ex_latch.valid && (o_ex_latch.rd != '0);  // r0 never written
        case (o_ex_latch.op)
            OP_ADDI, OP_ADD: alu_result = o_ex_latch.a + o_ex_latch.b;
            OP_SUB:          alu_result = o_ex_latch.a - o_ex_latch.b;
            OP_XOR:          alu_result = o_ex_latch.a ^ o_ex_latch.b;
            default: begin
                alu_result = '0;
                wb_en      = 1'b0;                      // NOP and HALT write nothing
            end
        endcase
    end

    // Forward the stage 2 result over the register file
    assign rs_val = (wb_en && o_ex_latch.rd == fetch.rs) ? alu_result : regs[fetch.rs];
    assign rt_val = (wb_en && o_ex_latch.rd == fetch.rt) ? alu_result : regs[fetch.rt];

    always_ff @(posedge i_clk) begin
        if (i_imem_we)
            imem[i_imem_addr] <= i_imem_data;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_pc       <= '0;
            o_retired  <= '0;
            o_ex_latch <= '0;                           // Stage 2 holds a bubble
            for (int i = 0; i < REG_COUNT; i++)
                regs[i] <= '0;
        end else if (step) begin
            o_pc       <= o_pc + 1'b1;
            o_ex_latch <= '{valid: 1'b1,
                            instr: fetch,
                            op:    fetch_op,
                            rd:    fetch.rd,
                            a:     rs_val,
                            b:     (fetch_op == OP_ADDI) ? imm_ext : rt_val};
            if (o_ex_latch.valid)
                o_retired <= o_retired + 1'b1;          // Counted as it leaves stage 2
            if (wb_en)
                regs[o_ex_latch.rd] <= alu_result;
        end
    end

endmodule

//--- rtl/debug_unit.sv
`timescale 1ns/1ps

module debug_unit (
    input  logic                            i_clk,
    input  logic                            i_reset,
    input  logic                            i_data_ready,   // Word from the receiver
    input  logic [uart_pkg::DATA_BITS-1:0]  i_data,
    input  logic                            i_program_end,  // HALT in stage 2
    input  core_pkg::ex_latch_t             i_ex_latch,
    input  logic [core_pkg::PC_BITS-1:0]    i_pc,
    input  logic [core_pkg::XLEN-1:0]       i_retired,
    input  logic [core_pkg::XLEN-1:0]       i_reg_data,     // Register at o_reg_addr
    output logic                            o_advance,
    output logic                            o_core_reset,
    output logic                            o_imem_we,
    output logic [core_pkg::PC_BITS-1:0]    o_imem_addr,
    output logic [core_pkg::XLEN-1:0]       o_imem_data,
    output logic [core_pkg::REG_BITS-1:0]   o_reg_addr,
    output logic [uart_pkg::DATA_BITS-1:0]  o_data_to_fifo,
    output logic                            o_write_en_fifo
);
    import core_pkg::*;

    localparam logic [3:0] DUMP_LAST = 4'(DUMP_WORDS - 1);

    typedef enum logic [1:0] {ST_IDLE, ST_LOADING, ST_RUNNING, ST_DUMPING} state_t;

    state_t             state;
    logic               run_mode;                       // High for RUN, low for STEP
    logic [6:0]         load_left;                      // Words still to load
    logic [PC_BITS-1:0] load_addr;
    logic [3:0]         dump_idx;
    logic [3:0]         reg_sel;
    logic [7:0]         cmd;
    logic [XLEN-1:0]    dump_word;

    assign cmd        = i_data[31:24];                  // Command code in the top byte
    assign o_advance  = (state == ST_RUNNING);          // Core ignores it once halted
    assign reg_sel    = dump_idx - DUMP_REG0;
    assign o_reg_addr = reg_sel[REG_BITS-1:0];

    always_comb begin
        case (dump_idx)
            DUMP_PC:      dump_word = {{(XLEN - PC_BITS){1'b0}}, i_pc};
            DUMP_INSTR:   dump_word = i_ex_latch.valid ? i_ex_latch.instr : '0;
            DUMP_RETIRED: dump_word = i_retired;
            default:      dump_word = i_reg_data;       // r0..r7
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state           <= ST_IDLE;
            run_mode        <= 1'b0;
            load_left       <= '0;
            load_addr       <= '0;
            dump_idx        <= '0;
            o_imem_we       <= 1'b0;
            o_core_reset    <= 1'b0;
            o_write_en_fifo <= 1'b0;
        end else begin
            o_imem_we       <= 1'b0;                    // Strobes last one cycle
            o_core_reset    <= 1'b0;
            o_write_en_fifo <= 1'b0;
            case (state)
                ST_IDLE: if (i_data_ready) begin
                    case (cmd)
                        CMD_LOAD: begin
                            load_left <= i_data[6:0];
                            load_addr <= '0;
                            if (i_data[6:0] != 7'd0)
                                state <= ST_LOADING;
                        end
                        CMD_RUN, CMD_STEP: begin
                            run_mode <= (cmd == CMD_RUN);
                            state    <= ST_RUNNING;
                        end
                        CMD_RESET: o_core_reset <= 1'b1;
                        default: ;                      // Unknown codes dropped
                    endcase
                end
                ST_LOADING: if (i_data_ready) begin
                    o_imem_we <= 1'b1;
                    load_addr <= load_addr + 1'b1;
                    load_left <= load_left - 1'b1;
                    if (load_left == 7'd1)
                        state <= ST_IDLE;
                end
                ST_RUNNING: if (!run_mode || i_program_end) begin  // One cycle for a step
                    state    <= ST_DUMPING;
                    dump_idx <= '0;
                end
                ST_DUMPING: begin
                    o_write_en_fifo <= 1'b1;            // One word per cycle
                    dump_idx        <= dump_idx + 1'b1;
                    if (dump_idx == DUMP_LAST)
                        state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        o_imem_addr    <= load_addr;
        o_imem_data    <= i_data;
        o_data_to_fifo <= dump_word;
    end

endmodule

//--- rtl/fifo_transmitter.sv
`timescale 1ns/1ps

module fifo_transmitter (
    input  logic                           i_clk,
    input  logic                           i_reset,
    input  logic                           i_wr,
    input  logic                           i_rd,        // Pop the head word
    input  logic [uart_pkg::DATA_BITS-1:0] i_wr_data,
    output logic [uart_pkg::DATA_BITS-1:0] o_rd_data,   // Head word, shown ahead
    output logic                           o_empty,
    output logic                           o_full
);
    import uart_pkg::*;

    localparam int AW = FIFO_ADDR_WIDTH;

    logic [DATA_BITS-1:0] mem [2**AW];
    logic [AW:0]          wr_ptr;                       // Extra bit tells full from empty
    logic [AW:0]          rd_ptr;

    assign o_empty   = (wr_ptr == rd_ptr);
    assign o_full    = (wr_ptr == {~rd_ptr[AW], rd_ptr[AW-1:0]});
    assign o_rd_data = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge i_clk) begin
        if (i_wr && !o_full)
            mem[wr_ptr[AW-1:0]] <= i_wr_data;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (i_wr && !o_full)
                wr_ptr <= wr_ptr + 1'b1;
            if (i_rd && !o_empty)
                rd_ptr <= rd_ptr + 1'b1;                // Pop on transmitter done
        end
    end

endmodule

//--- rtl/uart_transmitter.sv
`timescale 1ns/1ps

module uart_transmitter (
    input  logic                           i_clk,
    input  logic                           i_reset,
    input  logic                           i_tx_start,  // Level, FIFO not empty
    input  logic                           i_bd_tick,
    input  logic [uart_pkg::DATA_BITS-1:0] i_data,      // FIFO head word
    output logic                           o_tx_done,   // Pops the FIFO
    output logic                           o_tx
);
    import uart_pkg::*;

    localparam int            TW        = $clog2(TICKS_PER_BIT);
    localparam int            BW        = $clog2(DATA_BITS);
    localparam logic [TW-1:0] TICK_LAST = TW'(TICKS_PER_BIT - 1);
    localparam logic [BW-1:0] BIT_LAST  = BW'(DATA_BITS - 1);

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

    tx_state_t            state;
    logic [TW-1:0]        tick_cnt;
    logic [BW-1:0]        bit_cnt;
    logic [DATA_BITS-1:0] shift;                        // Word being serialized
    logic                 bit_end;

    assign bit_end   = i_bd_tick && (tick_cnt == TICK_LAST);
    assign o_tx_done = (state == TX_STOP) && bit_end;   // Same edge as return to idle
    assign o_tx      = (state == TX_DATA) ? shift[0] : (state != TX_START);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state    <= TX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            if (state != TX_IDLE && i_bd_tick)
                tick_cnt <= tick_cnt + 1'b1;            // Wraps at 16
            case (state)
                TX_IDLE: if (i_tx_start) begin          // Start is ignored while busy
                    state    <= TX_START;
                    tick_cnt <= '0;
                end
                TX_START: if (bit_end) begin
                    state   <= TX_DATA;
                    bit_cnt <= '0;
                end
                TX_DATA: if (bit_end) begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == BIT_LAST)
                        state <= TX_STOP;
                end
                TX_STOP: if (bit_end)
                    state <= TX_IDLE;
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == TX_IDLE && i_tx_start)
            shift <= i_data;                            // Latch head word at start
        else if (state == TX_DATA && bit_end)
            shift <= shift >> 1;                        // LSB first
    end

endmodule

//--- rtl/uart_receiver.sv
`timescale 1ns/1ps

module uart_receiver (
    input  logic                           i_clk,
    input  logic                           i_reset,
    input  logic                           i_rx,        // Serial line, idle high
    input  logic                           i_bd_tick,   // 16x oversampling tick
    output logic                           o_rx_done,   // Pulse at mid stop bit
    output logic [uart_pkg::DATA_BITS-1:0] o_data       // LSB received first
);
    import uart_pkg::*;

    localparam int            TW        = $clog2(TICKS_PER_BIT);
    localparam int            BW        = $clog2(DATA_BITS);
    localparam logic [TW-1:0] TICK_MID  = TW'(TICKS_PER_BIT / 2 - 1);
    localparam logic [TW-1:0] TICK_LAST = TW'(TICKS_PER_BIT - 1);
    localparam logic [BW-1:0] BIT_LAST  = BW'(DATA_BITS - 1);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t     state;
    logic [1:0]    rx_sync;                             // Two-flop synchronizer
    logic [TW-1:0] tick_cnt;
    logic [BW-1:0] bit_cnt;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state     <= RX_IDLE;
            rx_sync   <= 2'b11;                         // Line idles high
            tick_cnt  <= '0;
            bit_cnt   <= '0;
            o_rx_done <= 1'b0;
        end else begin
            rx_sync   <= {rx_sync[0], i_rx};
            o_rx_done <= 1'b0;
            case (state)
                RX_IDLE: if (!rx_sync[1]) begin         // Falling edge of start bit
                    state    <= RX_START;
                    tick_cnt <= '0;
                end
                RX_START: if (i_bd_tick) begin
                    if (tick_cnt == TICK_MID) begin     // Middle of start bit
                        state    <= rx_sync[1] ? RX_IDLE : RX_DATA;  // Glitch goes back
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                RX_DATA: if (i_bd_tick) begin
                    tick_cnt <= tick_cnt + 1'b1;        // Wraps at 16
                    if (tick_cnt == TICK_LAST) begin    // Middle of data bit
                        o_data  <= {rx_sync[1], o_data[DATA_BITS-1:1]};
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == BIT_LAST)
                            state <= RX_STOP;
                    end
                end
                RX_STOP: if (i_bd_tick) begin
                    tick_cnt <= tick_cnt + 1'b1;
                    if (tick_cnt == TICK_LAST) begin    // Middle of stop bit
                        o_rx_done <= 1'b1;
                        state     <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

//--- rtl/baud_rate_gen.sv
`timescale 1ns/1ps

module baud_rate_gen (
    input  logic i_clk,
    input  logic i_reset,
    output logic o_baud_tick                            // One cycle wide, every CLKS_PER_TICK
);
    import uart_pkg::*;

    localparam int            CW       = $clog2(CLKS_PER_TICK);
    localparam logic [CW-1:0] CNT_LAST = CW'(CLKS_PER_TICK - 1);

    logic [CW-1:0] clk_cnt;

    assign o_baud_tick = (clk_cnt == CNT_LAST);

    always_ff @(posedge i_clk) begin
        if (i_reset)
            clk_cnt <= '0;                              // Count restarts after reset
        else if (o_baud_tick)
            clk_cnt <= '0;
        else
            clk_cnt <= clk_cnt + 1'b1;
    end

endmodule

//--- rtl/core_pkg.sv
package core_pkg;

    localparam int XLEN       = 32;                     // Register and instruction width
    localparam int REG_COUNT  = 8;
    localparam int REG_BITS   = $clog2(REG_COUNT);
    localparam int IMEM_DEPTH = 64;
    localparam int PC_BITS    = $clog2(IMEM_DEPTH);
    localparam int DUMP_WORDS = 11;                     // PC, stage 2 word, retired, r0..r7

    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADDI = 4'd1,
        OP_ADD  = 4'd2,
        OP_SUB  = 4'd3,
        OP_XOR  = 4'd4,
        OP_HALT = 4'd15
    } opcode_t;

    localparam logic [7:0] CMD_LOAD  = 8'd1;            // Low 7 bits carry the word count
    localparam logic [7:0] CMD_RUN   = 8'd2;
    localparam logic [7:0] CMD_STEP  = 8'd3;
    localparam logic [7:0] CMD_RESET = 8'd4;

    localparam logic [3:0] DUMP_PC      = 4'd0;         // Word slots in the dump
    localparam logic [3:0] DUMP_INSTR   = 4'd1;
    localparam logic [3:0] DUMP_RETIRED = 4'd2;
    localparam logic [3:0] DUMP_REG0    = 4'd3;         // r0 here, r7 in the last slot

    typedef struct packed {
        logic [3:0]          opcode;                    // Bits 31..28
        logic [REG_BITS-1:0] rd;                        // Bits 27..25
        logic [REG_BITS-1:0] rs;                        // Bits 24..22
        logic [REG_BITS-1:0] rt;                        // Bits 21..19
        logic [2:0]          spare;
        logic [15:0]         imm;                       // Sign-extended immediate
    } instr_t;

    typedef struct packed {
        logic                valid;                     // Low for a bubble
        instr_t              instr;                     // Raw word for the dump
        opcode_t             op;                        // Decoded, unknown codes as NOP
        logic [REG_BITS-1:0] rd;
        logic [XLEN-1:0]     a;                         // rs value after forwarding
        logic [XLEN-1:0]     b;                         // rt value or immediate
    } ex_latch_t;

endpackage

//--- rtl/uart_pkg.sv
package uart_pkg;

    localparam int DATA_BITS       = 32;        // One host word per serial frame
    localparam int TICKS_PER_BIT   = 16;        // Oversampling ratio, stop bit included
    localparam int CLKS_PER_TICK   = 4;         // Clock cycles between baud ticks
    localparam int FIFO_ADDR_WIDTH = 4;         // 16 entries in the transmit FIFO

endpackage
